// ==== allocator/cfg_id_loop.sv ====
`timescale 1ns/1ps

module cfg_id_loop (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_start_rdy,
	input  lbuf_pkg::cfg_id_t i_beg_id,
	input  lbuf_pkg::cfg_id_t i_end_id,
	input  logic              i_step,
	output logic              o_start_ack,
	output lbuf_pkg::cfg_id_t o_id,
	output logic              o_busy
);
	import lbuf_pkg::*;

	id_loop_state_t state_r;
	cfg_id_t        id_r;
	cfg_id_t        id_nxt;
	logic           last_step;
	logic           empty_range;

	always_comb begin
		id_nxt    = id_r + cfg_id_t'(1);
		// Final step of the range, the next id would hit the end
		last_step = (state_r == LOOP_RUN) && i_step && (id_nxt == i_end_id);
		// Nothing to reserve, acknowledge at once
		empty_range = (state_r == LOOP_IDLE) && i_start_rdy && (i_beg_id == i_end_id);
		o_start_ack = last_step || empty_range;
	end

	assign o_id   = id_r;
	assign o_busy = (state_r == LOOP_RUN);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state_r <= LOOP_IDLE;
			id_r    <= '0;
		end else begin
			case (state_r)
				LOOP_IDLE: begin
					// Latch the first id of the held range
					if (i_start_rdy && !empty_range) begin
						state_r <= LOOP_RUN;
						id_r    <= i_beg_id;
					end
				end
				LOOP_RUN: begin
					if (last_step) begin
						state_r <= LOOP_IDLE;
					end else if (i_step) begin
						id_r <= id_nxt;
					end
				end
				default: state_r <= LOOP_IDLE;
			endcase
		end
	end

endmodule

// ==== allocator/lbuf_alloc_fifo.sv ====
`timescale 1ns/1ps
`include "lbuf_config.svh"

module lbuf_alloc_fifo (
	input  logic                i_clk,
	input  logic                i_rst,
	input  logic                i_push,
	input  lbuf_pkg::lbuf_row_t i_base,
	input  lbuf_pkg::lbuf_cnt_t i_size,
	input  logic                i_pop,
	output lbuf_pkg::lbuf_row_t o_head_base,
	output lbuf_pkg::lbuf_cnt_t o_head_size,
	output logic                o_full,
	output logic                o_empty
);
	import lbuf_pkg::*;

	localparam int DEPTH  = `LBUF_Q_DEPTH;
	localparam int PTR_BW = $clog2(DEPTH);

	typedef logic [PTR_BW-1:0] ptr_t;
	typedef logic [PTR_BW:0]   occ_t;

	// Reservation payload, row base and block size
	lbuf_row_t base_mem [DEPTH];
	lbuf_cnt_t size_mem [DEPTH];

	ptr_t wr_ptr_r;
	ptr_t rd_ptr_r;
	occ_t count_r;

	// Wrap at the queue depth, also for depths that are not a power of two
	function automatic ptr_t ptr_inc(input ptr_t p);
		return (p == ptr_t'(DEPTH-1)) ? '0 : p + ptr_t'(1);
	endfunction

	always_ff @(posedge i_clk) begin
		if (i_push) begin
			base_mem[wr_ptr_r] <= i_base;
			size_mem[wr_ptr_r] <= i_size;
		end
	end

	// Pointers and occupancy, push and pop may share a cycle
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			wr_ptr_r <= '0;
			rd_ptr_r <= '0;
			count_r  <= '0;
		end else begin
			if (i_push) begin
				wr_ptr_r <= ptr_inc(wr_ptr_r);
			end
			if (i_pop) begin
				rd_ptr_r <= ptr_inc(rd_ptr_r);
			end
			case ({i_push, i_pop})
				2'b10:   count_r <= count_r + occ_t'(1);
				2'b01:   count_r <= count_r - occ_t'(1);
				default: count_r <= count_r;
			endcase
		end
	end

	assign o_head_base = base_mem[rd_ptr_r];
	assign o_head_size = size_mem[rd_ptr_r];
	assign o_full      = (count_r == occ_t'(DEPTH));
	assign o_empty     = (count_r == '0);

endmodule

// ==== allocator/lbuf_allocator.sv ====
`timescale 1ns/1ps
`include "lbuf_config.svh"

module lbuf_allocator (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_alloc_rdy,
	input  lbuf_pkg::cfg_id_t    i_beg_id,
	input  lbuf_pkg::cfg_id_t    i_end_id,
	input  lbuf_pkg::lbuf_cnt_t  i_cur_size,
	input  lbuf_pkg::lbuf_cnt_t  i_free_size,
	input  logic                 i_linear_ack,
	input  logic                 i_allocated_ack,
	input  logic                 i_we_dval,
	input  logic                 i_free_dval,
	output lbuf_pkg::cfg_id_t    o_cur_id,
	output logic                 o_alloc_ack,
	output logic                 o_linear_rdy,
	output lbuf_pkg::lbuf_addr_t o_linear,
	output logic                 o_allocated_rdy
);
	import lbuf_pkg::*;

	localparam int        ROW_BW   = `LBUF_ADDR_BW - `LBUF_VEC_BW;
	localparam lbuf_cnt_t CAPACITY = lbuf_cnt_t'(1) << ROW_BW;

	// ======================================================================
	// Id loop and reservation gating
	// ======================================================================
	logic      loop_busy;
	logic      has_space;
	logic      can_alloc;
	logic      step;
	lbuf_cnt_t capacity_r;
	lbuf_cnt_t capacity_w;
	lbuf_row_t ptr_r;

	// Reservation queue strobes and head
	logic      fifo_push;
	logic      fifo_pop;
	logic      fifo_full;
	logic      fifo_empty;
	lbuf_row_t head_base;
	lbuf_cnt_t head_size;

	cfg_id_loop u_id_loop (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_start_rdy (i_alloc_rdy),
		.i_beg_id    (i_beg_id),
		.i_end_id    (i_end_id),
		.i_step      (step),
		.o_start_ack (o_alloc_ack),
		.o_id        (o_cur_id),
		.o_busy      (loop_busy)
	);

	// Reserve only with enough free rows and a free queue slot
	always_comb begin
		has_space = (capacity_r >= i_cur_size);
		can_alloc = has_space && !fifo_full;
		step      = loop_busy && can_alloc;
	end

	// Ring write pointer wraps at the ring size by itself
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			ptr_r <= '0;
		end else if (step) begin
			ptr_r <= ptr_r + i_cur_size[ROW_BW-1:0];
		end
	end

	// ======================================================================
	// Reservation queue
	// ======================================================================
	assign fifo_push = step;
	// Pop only a head that is released
	assign fifo_pop  = i_linear_ack && o_linear_rdy;

	lbuf_alloc_fifo u_alloc_fifo (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_push      (fifo_push),
		.i_base      (ptr_r),
		.i_size      (i_cur_size),
		.i_pop       (fifo_pop),
		.o_head_base (head_base),
		.o_head_size (head_size),
		.o_full      (fifo_full),
		.o_empty     (fifo_empty)
	);

	// Row base back to a vector address
	assign o_linear = {head_base, {`LBUF_VEC_BW{1'b0}}};

	// ======================================================================
	// Resource counters
	// ======================================================================
	lbuf_cnt_t filled_r;
	lbuf_cnt_t filled_w;
	lbuf_cnt_t notify_r;
	lbuf_cnt_t notify_w;

	// Capacity takes a reservation and a free in the same cycle
	always_comb begin
		capacity_w = capacity_r;
		if (fifo_push) begin
			capacity_w = capacity_w - i_cur_size;
		end
		if (i_free_dval) begin
			capacity_w = capacity_w + i_free_size;
		end
	end

	// Rows written so far with the surplus carried to the next entry
	always_comb begin
		filled_w = filled_r;
		if (i_we_dval) begin
			filled_w = filled_w + lbuf_cnt_t'(1);
		end
		if (fifo_pop) begin
			filled_w = filled_w - head_size;
		end
	end

	// Outstanding DMA notifications
	always_comb begin
		notify_w = notify_r;
		if (fifo_push) begin
			notify_w = notify_w + lbuf_cnt_t'(1);
		end
		if (i_allocated_ack && o_allocated_rdy) begin
			notify_w = notify_w - lbuf_cnt_t'(1);
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			capacity_r <= CAPACITY;
			filled_r   <= '0;
			notify_r   <= '0;
		end else begin
			capacity_r <= capacity_w;
			filled_r   <= filled_w;
			notify_r   <= notify_w;
		end
	end

	// Head is released once its rows are all in SRAM
	assign o_linear_rdy    = !fifo_empty && (filled_r >= head_size);
	assign o_allocated_rdy = (notify_r != '0);

endmodule

// ==== common/lbuf_config.svh ====
`ifndef LBUF_CONFIG_SVH
`define LBUF_CONFIG_SVH

// Width of a full SRAM vector address
`define LBUF_ADDR_BW 8

// Low address bits that select a vector inside one row
`define LBUF_VEC_BW 2

// Number of configuration ids in the size table
`define LBUF_N_CFG 4

// Depth of the pending reservation queue
`define LBUF_Q_DEPTH 4

`endif

// ==== common/lbuf_pkg.sv ====
`include "lbuf_config.svh"

package lbuf_pkg;

	// Full address as seen by the address consumer
	typedef logic [`LBUF_ADDR_BW-1:0] lbuf_addr_t;

	// Row index, also the ring write pointer
	typedef logic [`LBUF_ADDR_BW-`LBUF_VEC_BW-1:0] lbuf_row_t;

	// Row counts, one bit wider so a full ring fits
	typedef logic [`LBUF_ADDR_BW-`LBUF_VEC_BW:0] lbuf_cnt_t;

	// Config id, wide enough to hold the end id of a full range
	typedef logic [$clog2(`LBUF_N_CFG+1)-1:0] cfg_id_t;

	// Id loop FSM
	typedef enum logic {
		LOOP_IDLE,
		LOOP_RUN
	} id_loop_state_t;

endpackage

// ==== hdl/lbuf_size_table.sv ====
`timescale 1ns/1ps
`include "lbuf_config.svh"

module lbuf_size_table (
	input  logic                i_clk,
	input  logic                i_rst,
	input  logic                i_we,
	input  lbuf_pkg::cfg_id_t   i_wr_id,
	input  lbuf_pkg::lbuf_cnt_t i_wr_size,
	input  lbuf_pkg::cfg_id_t   i_rd_id_a,
	input  lbuf_pkg::cfg_id_t   i_rd_id_b,
	output lbuf_pkg::lbuf_cnt_t o_size_a,
	output lbuf_pkg::lbuf_cnt_t o_size_b
);
	import lbuf_pkg::*;

	localparam int      IDX_BW = $clog2(`LBUF_N_CFG);
	localparam cfg_id_t N_CFG  = cfg_id_t'(`LBUF_N_CFG);

	// One block size per config id
	lbuf_cnt_t size_r [`LBUF_N_CFG];

	// Software load port, one entry per cycle
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int i = 0; i < `LBUF_N_CFG; i++) begin
				size_r[i] <= '0;
			end
		end else if (i_we && (i_wr_id < N_CFG)) begin
			size_r[i_wr_id[IDX_BW-1:0]] <= i_wr_size;
		end
	end

	// Port a follows the allocation loop, port b the free id
	// Ids past the table read as zero
	assign o_size_a = (i_rd_id_a < N_CFG) ? size_r[i_rd_id_a[IDX_BW-1:0]] : '0;
	assign o_size_b = (i_rd_id_b < N_CFG) ? size_r[i_rd_id_b[IDX_BW-1:0]] : '0;

endmodule

// ==== hdl/lbuf_top.sv ====
`timescale 1ns/1ps

module lbuf_top (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_cfg_we,
	input  lbuf_pkg::cfg_id_t    i_cfg_id,
	input  lbuf_pkg::lbuf_cnt_t  i_cfg_size,
	input  logic                 i_alloc_rdy,
	input  lbuf_pkg::cfg_id_t    i_beg_id,
	input  lbuf_pkg::cfg_id_t    i_end_id,
	input  logic                 i_linear_ack,
	input  logic                 i_allocated_ack,
	input  logic                 i_we_dval,
	input  logic                 i_free_dval,
	input  lbuf_pkg::cfg_id_t    i_free_id,
	output logic                 o_alloc_ack,
	output logic                 o_linear_rdy,
	output lbuf_pkg::lbuf_addr_t o_linear,
	output logic                 o_allocated_rdy
);
	import lbuf_pkg::*;

	// Id currently walked by the allocator
	cfg_id_t   cur_id;
	lbuf_cnt_t cur_size;
	lbuf_cnt_t free_size;

	// Sizes for allocation and freeing, looked up in parallel
	lbuf_size_table u_size_table (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_we      (i_cfg_we),
		.i_wr_id   (i_cfg_id),
		.i_wr_size (i_cfg_size),
		.i_rd_id_a (cur_id),
		.i_rd_id_b (i_free_id),
		.o_size_a  (cur_size),
		.o_size_b  (free_size)
	);

	lbuf_allocator u_allocator (
		.i_clk           (i_clk),
		.i_rst           (i_rst),
		.i_alloc_rdy     (i_alloc_rdy),
		.i_beg_id        (i_beg_id),
		.i_end_id        (i_end_id),
		.i_cur_size      (cur_size),
		.i_free_size     (free_size),
		.i_linear_ack    (i_linear_ack),
		.i_allocated_ack (i_allocated_ack),
		.i_we_dval       (i_we_dval),
		.i_free_dval     (i_free_dval),
		.o_cur_id        (cur_id),
		.o_alloc_ack     (o_alloc_ack),
		.o_linear_rdy    (o_linear_rdy),
		.o_linear        (o_linear),
		.o_allocated_rdy (o_allocated_rdy)
	);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the lbuf testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/lbuf_sim

verilator --binary --timing --assert \
	--top-module lbuf_top_tb \
	-f vlog.f \
	-o lbuf_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
	echo "Simulation reported failures, see $LOG"
	exit 1
fi

echo "Simulation passed"
exit 0

// ==== verif/lbuf_props.sv ====
`timescale 1ns/1ps
`include "lbuf_config.svh"

module lbuf_props (
	input logic                i_clk,
	input logic                i_rst,
	input logic                i_alloc_rdy,
	input logic                i_alloc_ack,
	input lbuf_pkg::lbuf_cnt_t i_capacity,
	input logic                i_push,
	input logic                i_pop
);
	localparam int RING_ROWS = 1 << (`LBUF_ADDR_BW - `LBUF_VEC_BW);
	localparam int Q_DEPTH   = `LBUF_Q_DEPTH;

	// Queue occupancy rebuilt from the push and pop strobes
	int q_level;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			q_level <= 0;
		end else begin
			q_level <= q_level + int'(i_push) - int'(i_pop);
		end
	end

	// Frees never hand back more rows than the ring holds
	a_capacity_max: assert property (@(posedge i_clk) disable iff (i_rst)
		int'(i_capacity) <= RING_ROWS)
		else $error("capacity %0d is above the ring size", i_capacity);

	// Ack only while the requester holds its range
	a_ack_needs_rdy: assert property (@(posedge i_clk) disable iff (i_rst)
		i_alloc_ack |-> i_alloc_rdy)
		else $error("alloc ack seen with no request held");

	// Step gating keeps the queue from overflowing
	a_no_push_full: assert property (@(posedge i_clk) disable iff (i_rst)
		i_push |-> (q_level < Q_DEPTH))
		else $error("reservation queue pushed while full");

endmodule

bind lbuf_allocator lbuf_props u_props (
	.i_clk       (i_clk),
	.i_rst       (i_rst),
	.i_alloc_rdy (i_alloc_rdy),
	.i_alloc_ack (o_alloc_ack),
	.i_capacity  (capacity_r),
	.i_push      (fifo_push),
	.i_pop       (fifo_pop)
);

// ==== verif/lbuf_top_tb.sv ====
`timescale 1ns/1ps
`include "lbuf_config.svh"

module lbuf_top_tb;
	import lbuf_pkg::*;

	localparam int RING_ROWS       = 1 << (`LBUF_ADDR_BW - `LBUF_VEC_BW);
	localparam int STALL_CYCLES    = 10;
	localparam int CYCLES_PER_STEP = 40;

	// Table operations
	localparam int OP_CFG       = 0;
	localparam int OP_ALLOC     = 1;
	localparam int OP_WAIT_ACK  = 2;
	localparam int OP_WRITE     = 3;
	localparam int OP_FREE      = 4;
	localparam int OP_ACK_ALLOC = 5;
	localparam int OP_ACK_LIN   = 6;

	// One table row whose operands a and b depend on the operation
	typedef struct packed {
		int op;
		int a;
		int b;
		int exp;
	} step_t;

	logic       i_clk;
	logic       i_rst;
	logic       i_cfg_we;
	cfg_id_t    i_cfg_id;
	lbuf_cnt_t  i_cfg_size;
	logic       i_alloc_rdy;
	cfg_id_t    i_beg_id;
	cfg_id_t    i_end_id;
	logic       i_linear_ack;
	logic       i_allocated_ack;
	logic       i_we_dval;
	logic       i_free_dval;
	cfg_id_t    i_free_id;
	logic       o_alloc_ack;
	logic       o_linear_rdy;
	lbuf_addr_t o_linear;
	logic       o_allocated_rdy;

	lbuf_top lbuf_top_i (
		.i_clk           (i_clk),
		.i_rst           (i_rst),
		.i_cfg_we        (i_cfg_we),
		.i_cfg_id        (i_cfg_id),
		.i_cfg_size      (i_cfg_size),
		.i_alloc_rdy     (i_alloc_rdy),
		.i_beg_id        (i_beg_id),
		.i_end_id        (i_end_id),
		.i_linear_ack    (i_linear_ack),
		.i_allocated_ack (i_allocated_ack),
		.i_we_dval       (i_we_dval),
		.i_free_dval     (i_free_dval),
		.i_free_id       (i_free_id),
		.o_alloc_ack     (o_alloc_ack),
		.o_linear_rdy    (o_linear_rdy),
		.o_linear        (o_linear),
		.o_allocated_rdy (o_allocated_rdy)
	);

	step_t       steps[$];
	int          errors;
	int          cycle_count;
	int          cycle_limit;
	logic [31:0] lcg_state;

	// ========================================================================
	// Scoreboard model of sizes, ring pointer, capacity and queue
	// ========================================================================
	int size_m [`LBUF_N_CFG];
	int q_base [$];
	int q_size [$];
	int ptr_m;
	int cap_m;
	int filled_m;
	int notify_m;
	int pend_beg;
	int pend_end;

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			errors++;
			$display("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp, act);
		end
	endtask

	// Every id of the range fits capacity and queue room in order
	function automatic bit range_fits(input int beg, input int fin);
		int cap;
		int used;
		cap  = cap_m;
		used = q_base.size();
		for (int id = beg; id < fin; id++) begin
			if ((size_m[id] > cap) || (used >= `LBUF_Q_DEPTH)) begin
				return 1'b0;
			end
			cap -= size_m[id];
			used++;
		end
		return 1'b1;
	endfunction

	function automatic void reserve_range(input int beg, input int fin);
		for (int id = beg; id < fin; id++) begin
			q_base.push_back(ptr_m);
			q_size.push_back(size_m[id]);
			// Ring pointer wraps at the ring size
			ptr_m  = (ptr_m + size_m[id]) % RING_ROWS;
			cap_m -= size_m[id];
			notify_m++;
		end
	endfunction

	// Head released once its rows are written
	function automatic bit linear_rdy_m();
		if (q_size.size() == 0) begin
			return 1'b0;
		end
		return filled_m >= q_size[0];
	endfunction

	// ========================================================================
	// Bus actions driven on the falling edge
	// ========================================================================
	task automatic load_size(input int id, input int size);
		@(negedge i_clk);
		i_cfg_we   = 1'b1;
		i_cfg_id   = cfg_id_t'(id);
		i_cfg_size = lbuf_cnt_t'(size);
		size_m[id] = size;
		@(negedge i_clk);
		i_cfg_we = 1'b0;
	endtask

	task automatic finish_range();
		while (o_alloc_ack !== 1'b1) begin
			@(negedge i_clk);
		end
		// Rdy stays up through the ack cycle
		@(negedge i_clk);
		check_eq("o_alloc_ack", 32'd0, 32'(o_alloc_ack));
		i_alloc_rdy = 1'b0;
		reserve_range(pend_beg, pend_end);
		check_eq("o_allocated_rdy", 32'(notify_m != 0), 32'(o_allocated_rdy));
	endtask

	task automatic request_range(input int beg, input int fin, input int exp);
		if (range_fits(beg, fin) != (exp != 0)) begin
			errors++;
			$display("Table entry for ids %0d to %0d disagrees with the capacity model", beg, fin);
		end
		@(negedge i_clk);
		i_alloc_rdy = 1'b1;
		i_beg_id    = cfg_id_t'(beg);
		i_end_id    = cfg_id_t'(fin);
		pend_beg    = beg;
		pend_end    = fin;
		@(negedge i_clk);
		if (exp != 0) begin
			finish_range();
		end else begin
			// Stalled range holds back the ack while rdy stays high
			repeat (STALL_CYCLES) begin
				check_eq("o_alloc_ack", 32'd0, 32'(o_alloc_ack));
				@(negedge i_clk);
			end
		end
	endtask

	// Row bursts of random length with an idle cycle between them
	task automatic write_rows(input int n);
		int left;
		int len;
		left = n;
		while (left > 0) begin
			len = 1 + int'(lcg_next() >> 16) % 4;
			if (len > left) begin
				len = left;
			end
			repeat (len) begin
				@(negedge i_clk);
				check_eq("o_linear_rdy", 32'(linear_rdy_m()), 32'(o_linear_rdy));
				i_we_dval = 1'b1;
				filled_m++;
			end
			@(negedge i_clk);
			check_eq("o_linear_rdy", 32'(linear_rdy_m()), 32'(o_linear_rdy));
			i_we_dval = 1'b0;
			left -= len;
		end
	endtask

	task automatic pop_linear(input int exp);
		@(negedge i_clk);
		if (q_base.size() == 0) begin
			errors++;
			$display("Linear ack in the table with no reservation left in the model");
		end else begin
			check_eq("o_linear_rdy", 32'd1, 32'(o_linear_rdy));
			check_eq("o_linear", 32'(exp), 32'(o_linear));
			check_eq("o_linear (model)", 32'(q_base[0] << `LBUF_VEC_BW), 32'(o_linear));
			i_linear_ack = 1'b1;
			filled_m    -= q_size[0];
			void'(q_base.pop_front());
			void'(q_size.pop_front());
			@(negedge i_clk);
			check_eq("o_linear_rdy", 32'(linear_rdy_m()), 32'(o_linear_rdy));
			i_linear_ack = 1'b0;
		end
	endtask

	task automatic ack_allocated(input int n, input int exp);
		repeat (n) begin
			@(negedge i_clk);
			check_eq("o_allocated_rdy", 32'(notify_m != 0), 32'(o_allocated_rdy));
			i_allocated_ack = 1'b1;
			if (notify_m > 0) begin
				notify_m--;
			end
			@(negedge i_clk);
			i_allocated_ack = 1'b0;
		end
		check_eq("o_allocated_rdy", 32'(exp), 32'(o_allocated_rdy));
	endtask

	task automatic free_id(input int id);
		@(negedge i_clk);
		i_free_dval = 1'b1;
		i_free_id   = cfg_id_t'(id);
		cap_m      += size_m[id];
		@(negedge i_clk);
		i_free_dval = 1'b0;
	endtask

	function automatic void add_step(input int op, input int a, input int b, input int exp);
		step_t s;
		s.op  = op;
		s.a   = a;
		s.b   = b;
		s.exp = exp;
		steps.push_back(s);
	endfunction

	function automatic void build_table();
		// Sizes 3 5 2 4 give bases 0 3 8 10
		add_step(OP_CFG, 0, 3, 0);
		add_step(OP_CFG, 1, 5, 0);
		add_step(OP_CFG, 2, 2, 0);
		add_step(OP_CFG, 3, 4, 0);
		add_step(OP_ALLOC, 0, 4, 1);
		// Head of 3 rows not ready after 2 writes
		add_step(OP_WRITE, 2, 0, 0);
		add_step(OP_WRITE, 1, 0, 0);
		// Surplus rows carry to the next two heads
		add_step(OP_WRITE, 7, 0, 0);
		add_step(OP_ACK_LIN, 0, 0, 0);
		add_step(OP_ACK_LIN, 0, 0, 12);
		add_step(OP_ACK_LIN, 0, 0, 32);
		add_step(OP_WRITE, 4, 0, 0);
		add_step(OP_ACK_LIN, 0, 0, 40);
		add_step(OP_ACK_ALLOC, 3, 0, 1);
		add_step(OP_ACK_ALLOC, 1, 0, 0);
		add_step(OP_FREE, 0, 0, 0);
		add_step(OP_FREE, 1, 0, 0);
		add_step(OP_FREE, 2, 0, 0);
		add_step(OP_FREE, 3, 0, 0);
		// 80 rows asked of a 64 row ring stall on id 2
		add_step(OP_CFG, 0, 30, 0);
		add_step(OP_CFG, 1, 30, 0);
		add_step(OP_CFG, 2, 20, 0);
		add_step(OP_ALLOC, 0, 3, 0);
		add_step(OP_FREE, 0, 0, 0);
		add_step(OP_WAIT_ACK, 0, 0, 0);
		// Bases 14 44 then 10 after the wrap
		add_step(OP_WRITE, 30, 0, 0);
		add_step(OP_ACK_LIN, 0, 0, 56);
		add_step(OP_WRITE, 30, 0, 0);
		add_step(OP_ACK_LIN, 0, 0, 176);
		add_step(OP_WRITE, 20, 0, 0);
		add_step(OP_ACK_LIN, 0, 0, 40);
		add_step(OP_ACK_ALLOC, 3, 0, 0);
		add_step(OP_FREE, 1, 0, 0);
		add_step(OP_FREE, 2, 0, 0);
	endfunction

	// Watchdog whose limit scales with the table length
	initial begin
		cycle_count = 0;
		@(posedge i_clk);
		while ((cycle_limit == 0) || (cycle_count < cycle_limit)) begin
			@(posedge i_clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the table did not complete, %0d errors so far",
			cycle_count, errors);
		$display("Finished with errors");
		$finish;
	end

	// ========================================================================
	// Main sequence
	// ========================================================================
	initial begin
		i_rst           = 1'b1;
		i_cfg_we        = 1'b0;
		i_cfg_id        = '0;
		i_cfg_size      = '0;
		i_alloc_rdy     = 1'b0;
		i_beg_id        = '0;
		i_end_id        = '0;
		i_linear_ack    = 1'b0;
		i_allocated_ack = 1'b0;
		i_we_dval       = 1'b0;
		i_free_dval     = 1'b0;
		i_free_id       = '0;
		errors          = 0;
		lcg_state       = 32'h83fc_5d61;
		ptr_m           = 0;
		cap_m           = RING_ROWS;
		filled_m        = 0;
		notify_m        = 0;
		pend_beg        = 0;
		pend_end        = 0;
		for (int i = 0; i < `LBUF_N_CFG; i++) begin
			size_m[i] = 0;
		end
		build_table();
		cycle_limit = steps.size() * CYCLES_PER_STEP;

		repeat (3) @(posedge i_clk);
		@(negedge i_clk);
		i_rst = 1'b0;
		@(negedge i_clk);
		// Idle outputs out of reset
		check_eq("o_alloc_ack", 32'd0, 32'(o_alloc_ack));
		check_eq("o_linear_rdy", 32'd0, 32'(o_linear_rdy));
		check_eq("o_allocated_rdy", 32'd0, 32'(o_allocated_rdy));

		foreach (steps[i]) begin
			case (steps[i].op)
				OP_CFG:       load_size(steps[i].a, steps[i].b);
				OP_ALLOC:     request_range(steps[i].a, steps[i].b, steps[i].exp);
				OP_WAIT_ACK:  finish_range();
				OP_WRITE:     write_rows(steps[i].a);
				OP_FREE:      free_id(steps[i].a);
				OP_ACK_ALLOC: ack_allocated(steps[i].a, steps[i].exp);
				OP_ACK_LIN:   pop_linear(steps[i].exp);
				default: begin
					errors++;
					$display("Table step %0d holds an unknown operation", i);
				end
			endcase
		end

		@(negedge i_clk);
		$display("Run summary: %0d table steps, %0d errors", steps.size(), errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+common
common/lbuf_pkg.sv
hdl/lbuf_size_table.sv
allocator/cfg_id_loop.sv
allocator/lbuf_alloc_fifo.sv
allocator/lbuf_allocator.sv
hdl/lbuf_top.sv
verif/lbuf_props.sv
verif/lbuf_top_tb.sv
